// File: compile.f
+incdir+design
design/video_win_pkg.sv
design/host_cmd_decoder.sv
design/ar_select.sv
design/umuldiv.sv
design/ar_fit.sv
design/window_center.sv
design/video_win_top.sv
tb/tb_video_win.sv

// File: tb/tb_video_win.sv
// Testbench for the video window pipeline
// Host frame tasks that keep a shadow copy of the decoder registers
// Reference model of size selection, aspect fit and centring
// Compare process on each window strobe, timeout counter
`include "video_win_macros.svh"

module tb_video_win;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		video_win_pkg::dim_t hdmi_w;
		video_win_pkg::dim_t hdmi_h;
		video_win_pkg::dim_t hmin;
		video_win_pkg::dim_t hmax;
		video_win_pkg::dim_t vmin;
		video_win_pkg::dim_t vmax;
	} win_t;

	// About 41 windows of near 60 cycles each make a run of roughly 2500 cycles
	localparam int TIMEOUT_CYCLES = 4000;
	// Longer than one computed fit
	localparam int DRAIN_CYCLES = 100;

	logic                clk_sys = 1'b0;
	logic                resetd;
	logic                io_en;
	logic                io_strobe;
	logic [15:0]         io_din;
	video_win_pkg::ar_t  core_arx;
	video_win_pkg::ar_t  core_ary;
	video_win_pkg::dim_t hdmi_width;
	video_win_pkg::dim_t hdmi_height;
	logic                win_valid;
	video_win_pkg::dim_t hmin;
	video_win_pkg::dim_t hmax;
	video_win_pkg::dim_t vmin;
	video_win_pkg::dim_t vmax;

	// Shadow of the decoder registers
	video_win_pkg::dim_t sh_width;
	video_win_pkg::dim_t sh_height;
	video_win_pkg::dim_t sh_vset;
	video_win_pkg::dim_t sh_hset;
	logic                sh_fs;
	video_win_pkg::ar_t  sh_arc1x;
	video_win_pkg::ar_t  sh_arc1y;
	video_win_pkg::ar_t  sh_arc2x;
	video_win_pkg::ar_t  sh_arc2y;

	logic [15:0] frame_buf [0:7];
	int          frame_len;
	integer      seed = 32'hef03;
	int          win_seen = 0;
	int          exp_windows = 0;
	int          cycles = 0;
	logic        check_armed = 1'b1;
	int          ar_idx = 0;
	int          rnd_w;
	int          rnd_h;
	int          rnd_w0;
	int          rnd_h0;

	// Ratio pairs for the random part give fits below 4096
	int ar_x_tab [0:7] = '{4, 16, 5, 3, 21, 1, 9, 3};
	int ar_y_tab [0:7] = '{3, 9, 4, 2, 9, 1, 16, 4};

	video_win_top UUT (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_en       (io_en),
		.i_io_strobe   (io_strobe),
		.i_io_din      (io_din),
		.i_arx         (core_arx),
		.i_ary         (core_ary),
		.o_hdmi_width  (hdmi_width),
		.o_hdmi_height (hdmi_height),
		.o_win_valid   (win_valid),
		.o_hmin        (hmin),
		.o_hmax        (hmax),
		.o_vmin        (vmin),
		.o_vmax        (vmax)
	);

	always #10 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic win_t win_ref(
		input video_win_pkg::dim_t width,
		input video_win_pkg::dim_t height,
		input video_win_pkg::dim_t vset,
		input video_win_pkg::dim_t hset,
		input logic                fs,
		input video_win_pkg::ar_t  a1x,
		input video_win_pkg::ar_t  a1y,
		input video_win_pkg::ar_t  a2x,
		input video_win_pkg::ar_t  a2y,
		input video_win_pkg::ar_t  cx,
		input video_win_pkg::ar_t  cy
	);
		video_win_pkg::ar_t sx;
		video_win_pkg::ar_t sy;
		int                 hw;
		int                 hh;
		int                 ax;
		int                 ay;
		int                 fw;
		int                 fh;
		int                 vw;
		int                 vh;
		int                 ho;
		int                 vo;
		win_t               r;

		hw = (hset != 0 && hset < width) ? hset : width;
		hh = (vset != 0 && vset < height) ? vset : height;

		if (cy != 0) begin
			sx = cx;
			sy = cy;
		end else if (cx == 1) begin
			sx = a1x;
			sy = a1y;
		end else if (cx == 2) begin
			sx = a2x;
			sy = a2y;
		end else begin
			sx = '0;
			sy = '0;
		end
		ax = sx[11:0];
		ay = sy[11:0];

		if (fs || ax == 0 || ay == 0) begin
			fw = hw;
			fh = hh;
		end else if (sx[12] || sy[12]) begin
			// Literal picture size
			fw = ax;
			fh = ay;
		end else begin
			// Floor division keeps only 12 result bits
			fw = (hh * ax / ay) % 4096;
			fh = (hw * ay / ax) % 4096;
		end

		vw = (fw > hw) ? hw : fw;
		vh = (fh > hh) ? hh : fh;
		ho = (width - vw) / 2;
		vo = (height - vh) / 2;

		r.hdmi_w = video_win_pkg::dim_t'(hw);
		r.hdmi_h = video_win_pkg::dim_t'(hh);
		r.hmin   = video_win_pkg::dim_t'(ho);
		r.hmax   = video_win_pkg::dim_t'(ho + vw - 1);
		r.vmin   = video_win_pkg::dim_t'(vo);
		r.vmax   = video_win_pkg::dim_t'(vo + vh - 1);
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic compare_window();
		win_t want;

		want = win_ref(sh_width, sh_height, sh_vset, sh_hset, sh_fs,
			sh_arc1x, sh_arc1y, sh_arc2x, sh_arc2y, core_arx, core_ary);
		check_value("o_hdmi_width", hdmi_width, want.hdmi_w);
		check_value("o_hdmi_height", hdmi_height, want.hdmi_h);
		check_value("o_hmin", hmin, want.hmin);
		check_value("o_hmax", hmax, want.hmax);
		check_value("o_vmin", vmin, want.vmin);
		check_value("o_vmax", vmax, want.vmax);
	endtask

	// Window outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (!resetd && win_valid) begin
			win_seen = win_seen + 1;
			if (check_armed) compare_window();
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, an expected window never arrived", cycles);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// Host frames and waits
	//////////////////////////////////////////////////

	// One strobe every 2 cycles and the frame closes one cycle after the last word
	task automatic send_frame();
		for (int k = 0; k < frame_len; k++) begin
			io_en     = 1'b1;
			io_strobe = 1'b1;
			io_din    = frame_buf[k];
			@(negedge clk_sys);
			io_strobe = 1'b0;
			@(negedge clk_sys);
		end
		io_en = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic send_mode(input int w, input int h);
		frame_buf[0] = {8'h00, `VW_CMD_MODE};
		// Upper nibble is not part of the size
		frame_buf[1] = {4'h5, 12'(w)};
		// Porch and sync words
		frame_buf[2] = 16'h0058;
		frame_buf[3] = 16'h002c;
		frame_buf[4] = 16'h0094;
		frame_buf[5] = {4'ha, 12'(h)};
		frame_buf[6] = 16'h0004;
		frame_len    = 7;
		sh_width     = 12'(w);
		sh_height    = 12'(h);
		send_frame();
	endtask

	task automatic send_vset(input int v);
		frame_buf[0] = {8'h00, `VW_CMD_VSET};
		frame_buf[1] = {4'h0, 12'(v)};
		frame_len    = 2;
		sh_vset      = 12'(v);
		send_frame();
	endtask

	task automatic send_hset(input logic fs, input int hs);
		frame_buf[0] = {8'h00, `VW_CMD_HSET};
		frame_buf[1] = {fs, 3'b000, 12'(hs)};
		frame_len    = 2;
		sh_fs        = fs;
		sh_hset      = 12'(hs);
		send_frame();
	endtask

	task automatic send_arc(input int a1x, input int a1y, input int a2x, input int a2y);
		frame_buf[0] = {8'h00, `VW_CMD_ARC};
		frame_buf[1] = {3'b000, 13'(a1x)};
		frame_buf[2] = {3'b000, 13'(a1y)};
		frame_buf[3] = {3'b000, 13'(a2x)};
		frame_buf[4] = {3'b000, 13'(a2y)};
		frame_len    = 5;
		sh_arc1x     = 13'(a1x);
		sh_arc1y     = 13'(a1y);
		sh_arc2x     = 13'(a2x);
		sh_arc2y     = 13'(a2y);
		send_frame();
	endtask

	task automatic set_core_ratio(input int x, input int y);
		core_arx = 13'(x);
		core_ary = 13'(y);
	endtask

	task automatic await_windows(input int n);
		exp_windows = exp_windows + n;
		while (win_seen < exp_windows) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		resetd    = 1'b1;
		io_en     = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		core_arx  = '0;
		core_ary  = '0;
		sh_width  = `VW_DEF_WIDTH;
		sh_height = `VW_DEF_HEIGHT;
		sh_vset   = '0;
		sh_hset   = '0;
		sh_fs     = 1'b0;
		sh_arc1x  = '0;
		sh_arc1y  = '0;
		sh_arc2x  = '0;
		sh_arc2y  = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;

		// Default mode without a ratio
		await_windows(1);
		check_value("o_hmin", hmin, 0);
		check_value("o_hmax", hmax, 1919);
		check_value("o_vmin", vmin, 0);
		check_value("o_vmax", vmax, 1079);

		// 4:3 core on a 720p mode
		set_core_ratio(4, 3);
		await_windows(1);
		send_mode(1280, 720);
		await_windows(1);
		check_value("o_hdmi_width", hdmi_width, 1280);
		check_value("o_hmin", hmin, 160);
		check_value("o_hmax", hmax, 1119);
		check_value("o_vmin", vmin, 0);
		check_value("o_vmax", vmax, 719);

		// Reduced size, free scale, then values above the mode
		send_vset(600);
		await_windows(1);
		send_hset(1'b1, 1000);
		await_windows(1);
		send_hset(1'b0, 2000);
		await_windows(1);
		send_vset(900);
		await_windows(1);

		// Custom pairs, literal size and the zero fallback
		send_arc(5, 4, 13'h1000 | 640, 13'h1000 | 480);
		await_windows(1);
		set_core_ratio(1, 0);
		await_windows(1);
		set_core_ratio(2, 0);
		await_windows(1);
		set_core_ratio(3, 0);
		await_windows(1);

		for (int i = 0; i < 20; i++) begin
			rnd_w = 640 + ({$random(seed)} % 1281);
			rnd_h = 480 + ({$random(seed)} % 601);
			if (i % 2 == 0) begin
				// Ratio change starts a fit and both frames land while it runs
				rnd_w0 = 640 + ({$random(seed)} % 1281);
				rnd_h0 = 480 + ({$random(seed)} % 601);
				ar_idx = (ar_idx + 1 + ({$random(seed)} % 7)) % 8;
				check_armed = 1'b0;
				set_core_ratio(ar_x_tab[ar_idx], ar_y_tab[ar_idx]);
				send_mode(rnd_w0, rnd_h0);
				send_mode(rnd_w, rnd_h);
				await_windows(1);
				check_armed = 1'b1;
				await_windows(1);
			end else begin
				send_mode(rnd_w, rnd_h);
				await_windows(1);
			end
		end

		// No stray window may follow
		repeat (DRAIN_CYCLES) @(negedge clk_sys);
		if (win_seen != exp_windows) begin
			$display("Wrong number of windows, %0d seen and %0d expected",
				win_seen, exp_windows);
			$display("Testbench failed");
			$fatal(1);
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// File: design/video_win_top.sv
// Video window top level
// Host decoder, size and aspect selection, aspect fit, window centring

module video_win_top (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_io_en,
	input  logic                i_io_strobe,
	input  logic [15:0]         i_io_din,
	input  video_win_pkg::ar_t  i_arx,
	input  video_win_pkg::ar_t  i_ary,
	output video_win_pkg::dim_t o_hdmi_width,
	output video_win_pkg::dim_t o_hdmi_height,
	output logic                o_win_valid,
	output video_win_pkg::dim_t o_hmin,
	output video_win_pkg::dim_t o_hmax,
	output video_win_pkg::dim_t o_vmin,
	output video_win_pkg::dim_t o_vmax
);

	video_win_pkg::dim_t width;
	video_win_pkg::dim_t height;
	video_win_pkg::dim_t vset;
	video_win_pkg::dim_t hset;
	video_win_pkg::ar_t  arc1x;
	video_win_pkg::ar_t  arc1y;
	video_win_pkg::ar_t  arc2x;
	video_win_pkg::ar_t  arc2y;
	video_win_pkg::dim_t sel_arx;
	video_win_pkg::dim_t sel_ary;
	video_win_pkg::dim_t fit_w;
	video_win_pkg::dim_t fit_h;
	logic                freescale;
	logic                cfg_upd;
	logic                sel_valid;
	logic                sel_xy;
	logic                fit_valid;

	//////////////////////////////////////////////////
	// Stage 1, host side
	//////////////////////////////////////////////////

	host_cmd_decoder u_dec (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_en     (i_io_en),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_hset      (hset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y),
		.o_cfg_upd   (cfg_upd)
	);

	ar_select u_sel (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_sel_req     (cfg_upd),
		.i_width       (width),
		.i_height      (height),
		.i_vset        (vset),
		.i_hset        (hset),
		.i_arc1x       (arc1x),
		.i_arc1y       (arc1y),
		.i_arc2x       (arc2x),
		.i_arc2y       (arc2y),
		.i_arx         (i_arx),
		.i_ary         (i_ary),
		.o_sel_valid   (sel_valid),
		.o_hdmi_width  (o_hdmi_width),
		.o_hdmi_height (o_hdmi_height),
		.o_arx         (sel_arx),
		.o_ary         (sel_ary),
		.o_xy          (sel_xy)
	);

	//////////////////////////////////////////////////
	// Stages 3 and 4, fit and placement
	//////////////////////////////////////////////////

	ar_fit u_fit (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_sel_valid   (sel_valid),
		.i_hdmi_width  (o_hdmi_width),
		.i_hdmi_height (o_hdmi_height),
		.i_arx         (sel_arx),
		.i_ary         (sel_ary),
		.i_xy          (sel_xy),
		.i_freescale   (freescale),
		.o_fit_valid   (fit_valid),
		.o_fit_w       (fit_w),
		.o_fit_h       (fit_h)
	);

	window_center u_win (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_fit_valid   (fit_valid),
		.i_fit_w       (fit_w),
		.i_fit_h       (fit_h),
		.i_width       (width),
		.i_height      (height),
		.i_hdmi_width  (o_hdmi_width),
		.i_hdmi_height (o_hdmi_height),
		.o_win_valid   (o_win_valid),
		.o_hmin        (o_hmin),
		.o_hmax        (o_hmax),
		.o_vmin        (o_vmin),
		.o_vmax        (o_vmax)
	);

endmodule

// File: design/window_center.sv
// Window placement, last pipeline stage
// Fitted size clamped to the output size, then centred in the mode

module window_center (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_fit_valid,
	input  video_win_pkg::dim_t i_fit_w,
	input  video_win_pkg::dim_t i_fit_h,
	input  video_win_pkg::dim_t i_width,
	input  video_win_pkg::dim_t i_height,
	input  video_win_pkg::dim_t i_hdmi_width,
	input  video_win_pkg::dim_t i_hdmi_height,
	output logic                o_win_valid,
	output video_win_pkg::dim_t o_hmin,
	output video_win_pkg::dim_t o_hmax,
	output video_win_pkg::dim_t o_vmin,
	output video_win_pkg::dim_t o_vmax
);

	video_win_pkg::dim_t videow;
	video_win_pkg::dim_t videoh;
	video_win_pkg::dim_t hofs;
	video_win_pkg::dim_t vofs;

	assign videow = (i_fit_w > i_hdmi_width) ? i_hdmi_width : i_fit_w;
	assign videoh = (i_fit_h > i_hdmi_height) ? i_hdmi_height : i_fit_h;

	// Output size never exceeds the mode, so no underflow here
	assign hofs = video_win_pkg::dim_t'((i_width - videow) >> 1);
	assign vofs = video_win_pkg::dim_t'((i_height - videoh) >> 1);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_win_valid <= 1'b0;
			o_hmin      <= '0;
			o_hmax      <= '0;
			o_vmin      <= '0;
			o_vmax      <= '0;
		end else begin
			o_win_valid <= i_fit_valid;
			if (i_fit_valid) begin
				o_hmin <= hofs;
				o_hmax <= hofs + videow - 12'd1;
				o_vmin <= vofs;
				o_vmax <= vofs + videoh - 12'd1;
			end
		end
	end

	// Upstream never hands over an empty picture
	a_win_order: assert property (@(posedge clk_sys) disable iff (resetd)
		o_win_valid |-> o_hmin <= o_hmax);

endmodule

// File: design/ar_fit.sv
// Aspect fit sequencer, third pipeline stage
// Free-scale, no-ratio and literal-size shortcuts
// Width then height through one shared multiply-divide
// One request can wait while another is computing

module ar_fit (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_sel_valid,
	input  video_win_pkg::dim_t i_hdmi_width,
	input  video_win_pkg::dim_t i_hdmi_height,
	input  video_win_pkg::dim_t i_arx,
	input  video_win_pkg::dim_t i_ary,
	input  logic                i_xy,
	input  logic                i_freescale,
	output logic                o_fit_valid,
	output video_win_pkg::dim_t o_fit_w,
	output video_win_pkg::dim_t o_fit_h
);

	video_win_pkg::fit_state_t state;
	logic                      pending;
	logic                      md_start;
	logic                      md_busy;
	video_win_pkg::dim_t       md_mul1;
	video_win_pkg::dim_t       md_mul2;
	video_win_pkg::dim_t       md_div;
	video_win_pkg::dim_t       md_res;

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= video_win_pkg::FIT_IDLE;
			pending     <= 1'b0;
			md_start    <= 1'b0;
			o_fit_valid <= 1'b0;
		end else begin
			md_start    <= 1'b0;
			o_fit_valid <= 1'b0;

			// Served later with whatever stage 2 holds by then
			if (i_sel_valid && state != video_win_pkg::FIT_IDLE) pending <= 1'b1;

			case (state)
				video_win_pkg::FIT_IDLE: begin
					if (i_sel_valid || pending) begin
						pending <= 1'b0;
						if (i_freescale || i_arx == '0 || i_ary == '0) begin
							o_fit_w <= i_hdmi_width;
							o_fit_h <= i_hdmi_height;
							state   <= video_win_pkg::FIT_DONE;
						end else if (i_xy) begin
							// Core gave the picture size itself
							o_fit_w <= i_arx;
							o_fit_h <= i_ary;
							state   <= video_win_pkg::FIT_DONE;
						end else begin
							state <= video_win_pkg::FIT_MD1;
						end
					end
				end
				video_win_pkg::FIT_MD1: begin
					md_mul1  <= i_hdmi_height;
					md_mul2  <= i_arx;
					md_div   <= i_ary;
					md_start <= 1'b1;
					state    <= video_win_pkg::FIT_W1;
				end
				video_win_pkg::FIT_W1: begin
					if (!md_start && !md_busy) begin
						o_fit_w  <= md_res;
						md_mul1  <= i_hdmi_width;
						md_mul2  <= i_ary;
						md_div   <= i_arx;
						md_start <= 1'b1;
						state    <= video_win_pkg::FIT_W2;
					end
				end
				video_win_pkg::FIT_W2: begin
					if (!md_start && !md_busy) begin
						o_fit_h <= md_res;
						state   <= video_win_pkg::FIT_DONE;
					end
				end
				default: begin
					o_fit_valid <= 1'b1;
					state       <= video_win_pkg::FIT_IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/umuldiv.sv
// Sequential unsigned multiply-then-divide
// One load cycle forms the product, then a restoring divider
// produces one quotient bit per cycle, floor rounding
`include "video_win_macros.svh"

module umuldiv (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_start,
	input  video_win_pkg::dim_t i_mul1,
	input  video_win_pkg::dim_t i_mul2,
	input  video_win_pkg::dim_t i_div,
	output logic                o_busy,
	output video_win_pkg::dim_t o_result
);

	// Dividend shifts out at the top while quotient bits enter at the bottom
	video_win_pkg::prod_t dvd;
	video_win_pkg::dim_t  rem;
	video_win_pkg::dim_t  dvs;
	logic [`VW_DIM_W:0]   trial;
	logic [4:0]           step;

	assign trial    = {rem, dvd[`VW_PROD_W-1]};
	assign o_result = dvd[`VW_DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= 5'(`VW_PROD_W);
		end else if (o_busy) begin
			step <= step - 5'd1;
			if (step == 5'd1) o_busy <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			dvd <= video_win_pkg::prod_t'(i_mul1) * video_win_pkg::prod_t'(i_mul2);
			rem <= '0;
			dvs <= i_div;
		end else if (o_busy) begin
			// Subtract when the partial remainder covers the divisor
			if (trial >= {1'b0, dvs}) begin
				rem <= video_win_pkg::dim_t'(trial - {1'b0, dvs});
				dvd <= {dvd[`VW_PROD_W-2:0], 1'b1};
			end else begin
				rem <= trial[`VW_DIM_W-1:0];
				dvd <= {dvd[`VW_PROD_W-2:0], 1'b0};
			end
		end
	end

	// Caller waits for the previous result
	a_no_restart: assert property (@(posedge clk_sys) disable iff (resetd)
		i_start |-> !o_busy);

endmodule

// File: design/ar_select.sv
// Second pipeline stage that selects the output size and aspect source
// Reduced size against the mode size
// Core ratio, custom pair 1 or 2, or no ratio
// Request strobe on host update, core ratio change or reset exit

module ar_select (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_sel_req,
	input  video_win_pkg::dim_t i_width,
	input  video_win_pkg::dim_t i_height,
	input  video_win_pkg::dim_t i_vset,
	input  video_win_pkg::dim_t i_hset,
	input  video_win_pkg::ar_t  i_arc1x,
	input  video_win_pkg::ar_t  i_arc1y,
	input  video_win_pkg::ar_t  i_arc2x,
	input  video_win_pkg::ar_t  i_arc2y,
	input  video_win_pkg::ar_t  i_arx,
	input  video_win_pkg::ar_t  i_ary,
	output logic                o_sel_valid,
	output video_win_pkg::dim_t o_hdmi_width,
	output video_win_pkg::dim_t o_hdmi_height,
	output video_win_pkg::dim_t o_arx,
	output video_win_pkg::dim_t o_ary,
	output logic                o_xy
);

	video_win_pkg::ar_t  arx_d;
	video_win_pkg::ar_t  ary_d;
	video_win_pkg::ar_t  sel_x;
	video_win_pkg::ar_t  sel_y;
	video_win_pkg::dim_t hdmi_w;
	video_win_pkg::dim_t hdmi_h;
	logic                init_pend;
	logic                ar_chg;
	logic                sel_go;

	// Reduced size only when set and smaller than the mode
	assign hdmi_w = (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
	assign hdmi_h = (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

	always_comb begin
		if (i_ary != '0) begin
			sel_x = i_arx;
			sel_y = i_ary;
		end else if (i_arx == 13'd1) begin
			sel_x = i_arc1x;
			sel_y = i_arc1y;
		end else if (i_arx == 13'd2) begin
			sel_x = i_arc2x;
			sel_y = i_arc2y;
		end else begin
			sel_x = '0;
			sel_y = '0;
		end
	end

	assign ar_chg = (i_arx != arx_d) || (i_ary != ary_d);
	assign sel_go = i_sel_req | ar_chg | init_pend;

	// Core ratio of the previous cycle for change detection
	always_ff @(posedge clk_sys) begin
		arx_d <= i_arx;
		ary_d <= i_ary;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			init_pend   <= 1'b1;
			o_sel_valid <= 1'b0;
		end else begin
			init_pend   <= 1'b0;
			o_sel_valid <= sel_go;
		end
	end

	// Held between requests
	always_ff @(posedge clk_sys) begin
		if (sel_go) begin
			o_hdmi_width  <= hdmi_w;
			o_hdmi_height <= hdmi_h;
			o_arx         <= sel_x[11:0];
			o_ary         <= sel_y[11:0];
			o_xy          <= sel_x[12] | sel_y[12];
		end
	end

endmodule

// File: design/host_cmd_decoder.sv
// Host command decoder, first pipeline stage
// Command latch and parameter word index
// Mode size, VSET, HSET with free-scale flag, custom aspect pairs
// Update strobe when a frame with a kept command closes
`include "video_win_macros.svh"

module host_cmd_decoder (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_io_en,
	input  logic                i_io_strobe,
	input  logic [15:0]         i_io_din,
	output video_win_pkg::dim_t o_width,
	output video_win_pkg::dim_t o_height,
	output video_win_pkg::dim_t o_vset,
	output video_win_pkg::dim_t o_hset,
	output logic                o_freescale,
	output video_win_pkg::ar_t  o_arc1x,
	output video_win_pkg::ar_t  o_arc1y,
	output video_win_pkg::ar_t  o_arc2x,
	output video_win_pkg::ar_t  o_arc2y,
	output logic                o_cfg_upd
);

	logic       has_cmd;
	logic [7:0] cmd;
	logic [3:0] cnt;
	logic       en_d;
	logic       kept;

	assign kept = (cmd == `VW_CMD_MODE) || (cmd == `VW_CMD_VSET) ||
		(cmd == `VW_CMD_HSET) || (cmd == `VW_CMD_ARC);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= '0;
			cnt         <= '0;
			en_d        <= 1'b0;
			o_cfg_upd   <= 1'b0;
			o_width     <= `VW_DEF_WIDTH;
			o_height    <= `VW_DEF_HEIGHT;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else begin
			en_d <= i_io_en;
			// Frame closed, cmd and has_cmd still hold its state here
			o_cfg_upd <= en_d & ~i_io_en & has_cmd & kept;

			if (!i_io_en) begin
				has_cmd <= 1'b0;
			end else if (i_io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= i_io_din[7:0];
					cnt     <= '0;
				end else begin
					// Index saturates, only the first words matter
					if (cnt != 4'hf) cnt <= cnt + 4'd1;

					case (cmd)
						`VW_CMD_MODE: begin
							// Porch and sync words are skipped
							if (cnt == 4'd0) o_width <= i_io_din[11:0];
							if (cnt == 4'd4) o_height <= i_io_din[11:0];
						end
						`VW_CMD_VSET: begin
							if (cnt == 4'd0) o_vset <= i_io_din[11:0];
						end
						`VW_CMD_HSET: begin
							if (cnt == 4'd0) begin
								o_freescale <= i_io_din[15];
								o_hset      <= i_io_din[11:0];
							end
						end
						`VW_CMD_ARC: begin
							case (cnt)
								4'd0: o_arc1x <= i_io_din[12:0];
								4'd1: o_arc1y <= i_io_din[12:0];
								4'd2: o_arc2x <= i_io_din[12:0];
								4'd3: o_arc2y <= i_io_din[12:0];
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
	end

	// Host only strobes inside a framed command
	a_strobe_in_frame: assert property (@(posedge clk_sys) disable iff (resetd)
		i_io_strobe |-> i_io_en);

endmodule

// File: design/video_win_pkg.sv
// Shared types of the video window pipeline
// Screen dimension, aspect value, product and the fit FSM state
`include "video_win_macros.svh"

package video_win_pkg;

	// Unsigned screen dimension
	typedef logic [`VW_DIM_W-1:0] dim_t;

	// Aspect value as sent by the host or the core
	typedef logic [`VW_AR_W-1:0] ar_t;

	// Multiply-divide dividend
	typedef logic [`VW_PROD_W-1:0] prod_t;

	// Aspect fit sequencer
	typedef enum logic [2:0] {
		FIT_IDLE,
		// Load first multiply-divide
		FIT_MD1,
		// Wait for width, then load the second one
		FIT_W1,
		// Wait for height
		FIT_W2,
		FIT_DONE
	} fit_state_t;

endpackage

// File: design/video_win_macros.svh
// Command codes of the host commands that the window pipeline decodes
// Widths of screen dimensions, aspect values and the multiply-divide product
// Output mode size loaded at reset
`ifndef VIDEO_WIN_MACROS_SVH
`define VIDEO_WIN_MACROS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// Screen dimension in pixels or lines
`define VW_DIM_W 12
// Aspect value, top bit flags a literal size
`define VW_AR_W 13
// Full product of two dimensions
`define VW_PROD_W 24

//////////////////////////////////////////////////
// Host commands
//////////////////////////////////////////////////

`define VW_CMD_MODE 8'h20
`define VW_CMD_VSET 8'h27
`define VW_CMD_HSET 8'h37
`define VW_CMD_ARC  8'h3A

// Mode after reset, 1080p
`define VW_DEF_WIDTH  12'd1920
`define VW_DEF_HEIGHT 12'd1080

`endif
